// File: project.f
source/cpu_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/register_file.sv
source/execute_unit.sv
source/command_port.sv
source/cpu_top.sv
verif/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f project.f -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
fi
exit 1

// File: source/command_port.sv
`timescale 1ns/1ps

module command_port (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue,
	input  cpu_pkg::sprite_op_t op,
	input  cpu_pkg::reg_addr_t  tag,
	input  cpu_pkg::word_t      data,
	input  logic                cmd_ack,
	output logic                busy,
	output logic                cmd_req,
	output cpu_pkg::sprite_op_t cmd_op,
	output cpu_pkg::reg_addr_t  cmd_tag,
	output cpu_pkg::word_t      cmd_data
);
	typedef enum logic [1:0] {
		idle,
		wait_ack_high,
		wait_ack_low
	} cmd_state_e;

	cmd_state_e state;

	// four-phase handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			case (state)
				idle:          if (issue) state <= wait_ack_high;
				wait_ack_high: if (cmd_ack) state <= wait_ack_low;
				wait_ack_low:  if (!cmd_ack) state <= idle;
				default:       state <= idle;
			endcase
		end
	end

	// command held stable for the whole transfer
	always_ff @(posedge clk) begin
		if (issue && state == idle) begin
			cmd_op <= op;
			cmd_tag <= tag;
			cmd_data <= data;
		end
	end

	assign busy = state != idle;
	assign cmd_req = state == wait_ack_high;

	assert property (@(posedge clk) disable iff (!rst_n) $fell(cmd_req) |-> $past(cmd_ack))
		else $error("cmd_req dropped before cmd_ack");
	assert property (@(posedge clk) disable iff (!rst_n) issue |-> !busy)
		else $error("command issued while the port is busy");

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

	////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [4:0]  opcode_t;
	typedef logic [2:0]  alu_op_t;
	typedef logic [2:0]  branch_cond_t;
	typedef logic [2:0]  sprite_op_t;

	// zero, sign, overflow
	typedef logic [2:0]  flags_t;

	localparam int flag_zero     = 2;
	localparam int flag_sign     = 1;
	localparam int flag_overflow = 0;

	////////////////////////////////////////////////////////////
	// opcodes of the kept instructions
	////////////////////////////////////////////////////////////

	localparam opcode_t op_add  = 5'd0;
	localparam opcode_t op_addi = 5'd1;
	localparam opcode_t op_sub  = 5'd2;
	localparam opcode_t op_and  = 5'd3;
	localparam opcode_t op_andi = 5'd4;
	localparam opcode_t op_or   = 5'd5;
	localparam opcode_t op_ori  = 5'd6;
	localparam opcode_t op_xor  = 5'd7;
	localparam opcode_t op_sll  = 5'd8;
	localparam opcode_t op_srl  = 5'd9;
	localparam opcode_t op_sra  = 5'd10;
	localparam opcode_t op_lli  = 5'd11;
	localparam opcode_t op_lui  = 5'd12;
	localparam opcode_t op_b    = 5'd17;
	localparam opcode_t op_bl   = 5'd18;
	localparam opcode_t op_ret  = 5'd19;
	localparam opcode_t op_wfb  = 5'd21;
	localparam opcode_t op_dfb  = 5'd22;
	localparam opcode_t op_ls   = 5'd23;
	localparam opcode_t op_ds   = 5'd24;
	localparam opcode_t op_cs   = 5'd25;
	localparam opcode_t op_rs   = 5'd26;

	// alu functions
	localparam alu_op_t alu_add = 3'd0;
	localparam alu_op_t alu_sub = 3'd1;
	localparam alu_op_t alu_and = 3'd2;
	localparam alu_op_t alu_or  = 3'd3;
	localparam alu_op_t alu_xor = 3'd4;
	localparam alu_op_t alu_sll = 3'd5;
	localparam alu_op_t alu_srl = 3'd6;
	localparam alu_op_t alu_sra = 3'd7;

	// branch conditions
	localparam branch_cond_t cond_ne       = 3'd0;
	localparam branch_cond_t cond_eq       = 3'd1;
	localparam branch_cond_t cond_gt       = 3'd2;
	localparam branch_cond_t cond_lt       = 3'd3;
	localparam branch_cond_t cond_ge       = 3'd4;
	localparam branch_cond_t cond_le       = 3'd5;
	localparam branch_cond_t cond_overflow = 3'd6;
	localparam branch_cond_t cond_always   = 3'd7;

	// sprite commands
	localparam sprite_op_t sprite_wfb = 3'd0;
	localparam sprite_op_t sprite_dfb = 3'd1;
	localparam sprite_op_t sprite_ls  = 3'd2;
	localparam sprite_op_t sprite_ds  = 3'd3;
	localparam sprite_op_t sprite_cs  = 3'd4;
	localparam sprite_op_t sprite_rs  = 3'd5;

	// instruction fields
	localparam int opcode_msb = 31;
	localparam int opcode_lsb = 27;
	localparam int dest_msb   = 26;
	localparam int dest_lsb   = 22;
	localparam int src1_msb   = 21;
	localparam int src1_lsb   = 17;
	localparam int src2_msb   = 16;
	localparam int src2_lsb   = 12;
	localparam int imm_msb    = 15;
	localparam int imm_lsb    = 0;
	localparam int cond_msb   = 26;
	localparam int cond_lsb   = 24;

endpackage

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int imem_addr_width = 8
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       run,
	input  logic                       prog_write,
	input  logic [imem_addr_width-1:0] prog_address,
	input  cpu_pkg::word_t             prog_data,
	input  logic                       cmd_ack,
	output logic                       cmd_req,
	output cpu_pkg::sprite_op_t        cmd_op,
	output cpu_pkg::reg_addr_t         cmd_tag,
	output cpu_pkg::word_t             cmd_data
);
	import cpu_pkg::*;

	// fetch and decode
	word_t instruction;
	logic [imem_addr_width-1:0] instruction_pc;
	logic stall, redirect;
	logic [imem_addr_width-1:0] redirect_pc;

	// decode to execute
	logic ex_valid, ex_use_imm, ex_stall;
	opcode_t ex_opcode;
	alu_op_t ex_alu_op;
	word_t ex_op1, ex_op2, ex_imm;
	reg_addr_t ex_dest;
	flags_t flags;

	// register file
	reg_addr_t read_address1, read_address2, write_address;
	word_t read_data1, read_data2, write_data;
	logic write, write_lower, write_upper;

	// command path
	logic issue, busy;
	sprite_op_t op;
	reg_addr_t tag;
	word_t data;

	fetch_unit #(.imem_addr_width(imem_addr_width)) fetch_i (.*);

	decode_unit #(.imem_addr_width(imem_addr_width)) decode_i (.*);

	register_file register_file_i (.*);

	execute_unit execute_i (.*);

	command_port command_port_i (.*);

endmodule

// File: source/decode_unit.sv
`timescale 1ns/1ps

module decode_unit #(
	parameter int imem_addr_width = 8
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cpu_pkg::word_t             instruction,
	input  logic [imem_addr_width-1:0] instruction_pc,
	input  cpu_pkg::flags_t            flags,
	input  logic                       ex_stall,
	input  cpu_pkg::word_t             read_data1,
	input  cpu_pkg::word_t             read_data2,
	output logic                       stall,
	output logic                       redirect,
	output logic [imem_addr_width-1:0] redirect_pc,
	output cpu_pkg::reg_addr_t         read_address1,
	output cpu_pkg::reg_addr_t         read_address2,
	output logic                       ex_valid,
	output cpu_pkg::opcode_t           ex_opcode,
	output cpu_pkg::alu_op_t           ex_alu_op,
	output logic                       ex_use_imm,
	output cpu_pkg::word_t             ex_op1,
	output cpu_pkg::word_t             ex_op2,
	output cpu_pkg::word_t             ex_imm,
	output cpu_pkg::reg_addr_t         ex_dest
);
	import cpu_pkg::*;

	word_t ifid_instruction;
	logic [imem_addr_width-1:0] ifid_pc;
	logic ifid_is_no_op;
	logic [imem_addr_width-1:0] link_reg;
	logic [imem_addr_width-1:0] pc_plus_one;
	logic idex_sets_flags;

	opcode_t opcode;
	branch_cond_t cond;
	word_t immediate;
	alu_op_t alu_op;
	logic use_imm, sets_flags, is_sprite;
	logic is_branch, is_link, is_ret;
	logic should_branch, flag_hazard;

	////////////////////////////////////////////////////////////
	// IF/ID register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ifid_instruction <= '0;
			ifid_pc <= '0;
			ifid_is_no_op <= 1'b1;
		end else if (redirect) begin
			// squash the word fetched behind the branch
			ifid_instruction <= '0;
			ifid_is_no_op <= 1'b1;
		end else if (!stall) begin
			ifid_instruction <= instruction;
			ifid_pc <= instruction_pc;
			ifid_is_no_op <= instruction == '0;
		end
	end

	////////////////////////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////////////////////////

	assign opcode = ifid_instruction[opcode_msb:opcode_lsb];
	assign cond = ifid_instruction[cond_msb:cond_lsb];
	assign immediate = {{16{ifid_instruction[imm_msb]}}, ifid_instruction[imm_msb:imm_lsb]};

	always_comb begin
		case (opcode)
			op_sub:         alu_op = alu_sub;
			op_and, op_andi: alu_op = alu_and;
			op_or, op_ori:  alu_op = alu_or;
			op_xor:         alu_op = alu_xor;
			op_sll:         alu_op = alu_sll;
			op_srl:         alu_op = alu_srl;
			op_sra:         alu_op = alu_sra;
			default:        alu_op = alu_add;
		endcase
	end

	assign use_imm = opcode inside {op_addi, op_andi, op_ori};
	assign sets_flags = opcode inside {[op_add:op_sra]};
	assign is_sprite = opcode inside {[op_wfb:op_rs]};
	assign is_branch = opcode inside {op_b, op_bl};
	assign is_link = opcode == op_bl;
	assign is_ret = opcode == op_ret;

	// sprite ops read the destination field as their second operand
	assign read_address1 = ifid_instruction[src1_msb:src1_lsb];
	assign read_address2 = is_sprite ? ifid_instruction[dest_msb:dest_lsb]
	                                 : ifid_instruction[src2_msb:src2_lsb];

	always_comb begin
		should_branch = 1'b0;
		case (cond)
			cond_ne:       should_branch = !flags[flag_zero];
			cond_eq:       should_branch = flags[flag_zero];
			cond_gt:       should_branch = !flags[flag_zero] && !flags[flag_sign];
			cond_lt:       should_branch = !flags[flag_zero] && flags[flag_sign];
			cond_ge:       should_branch = flags[flag_zero] || !flags[flag_sign];
			cond_le:       should_branch = flags[flag_zero] || flags[flag_sign];
			cond_overflow: should_branch = flags[flag_overflow];
			cond_always:   should_branch = 1'b1;
			default:       should_branch = 1'b0;
		endcase
	end

	// flags from the op in execute are not visible until next cycle
	assign flag_hazard = !ifid_is_no_op && is_branch && ex_valid && idex_sets_flags;
	assign stall = ex_stall || flag_hazard;

	assign pc_plus_one = ifid_pc + 1'b1;
	assign redirect = !stall && !ifid_is_no_op && ((is_branch && should_branch) || is_ret);
	assign redirect_pc = is_ret ? link_reg : pc_plus_one + immediate[imem_addr_width-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			link_reg <= '0;
		end else if (!stall && !ifid_is_no_op && is_link && should_branch) begin
			link_reg <= pc_plus_one;
		end
	end

	////////////////////////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_opcode <= '0;
			ex_alu_op <= alu_add;
			ex_use_imm <= 1'b0;
			idex_sets_flags <= 1'b0;
		end else if (!ex_stall) begin
			// a held branch leaves a bubble behind it
			ex_valid <= !ifid_is_no_op && !flag_hazard;
			ex_opcode <= opcode;
			ex_alu_op <= alu_op;
			ex_use_imm <= use_imm;
			idex_sets_flags <= sets_flags;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_stall) begin
			ex_op1 <= read_data1;
			ex_op2 <= read_data2;
			ex_imm <= immediate;
			ex_dest <= ifid_instruction[dest_msb:dest_lsb];
		end
	end

	// the slot squashed by a redirect never reaches execute
	assert property (@(posedge clk) disable iff (!rst_n) redirect |-> ##2 !ex_valid)
		else $error("flushed slot entered execute");

endmodule

// File: source/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ex_valid,
	input  cpu_pkg::opcode_t    ex_opcode,
	input  cpu_pkg::alu_op_t    ex_alu_op,
	input  logic                ex_use_imm,
	input  cpu_pkg::word_t      ex_op1,
	input  cpu_pkg::word_t      ex_op2,
	input  cpu_pkg::word_t      ex_imm,
	input  cpu_pkg::reg_addr_t  ex_dest,
	input  logic                busy,
	output logic                ex_stall,
	output cpu_pkg::flags_t     flags,
	output logic                write,
	output logic                write_lower,
	output logic                write_upper,
	output cpu_pkg::reg_addr_t  write_address,
	output cpu_pkg::word_t      write_data,
	output logic                issue,
	output cpu_pkg::sprite_op_t op,
	output cpu_pkg::reg_addr_t  tag,
	output cpu_pkg::word_t      data
);
	import cpu_pkg::*;

	word_t operand_b;
	word_t alu_result;
	logic alu_overflow;
	logic is_alu, is_sprite;

	assign is_alu = ex_opcode inside {[op_add:op_sra]};
	assign is_sprite = ex_opcode inside {[op_wfb:op_rs]};

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	assign operand_b = ex_use_imm ? ex_imm : ex_op2;

	always_comb begin
		alu_overflow = 1'b0;
		case (ex_alu_op)
			alu_add: begin
				alu_result = ex_op1 + operand_b;
				alu_overflow = (ex_op1[31] == operand_b[31]) && (alu_result[31] != ex_op1[31]);
			end
			alu_sub: begin
				alu_result = ex_op1 - operand_b;
				alu_overflow = (ex_op1[31] != operand_b[31]) && (alu_result[31] != ex_op1[31]);
			end
			alu_and: alu_result = ex_op1 & operand_b;
			alu_or:  alu_result = ex_op1 | operand_b;
			alu_xor: alu_result = ex_op1 ^ operand_b;
			alu_sll: alu_result = ex_op1 << operand_b[4:0];
			alu_srl: alu_result = ex_op1 >> operand_b[4:0];
			default: alu_result = $signed(ex_op1) >>> operand_b[4:0];
		endcase
	end

	// status flags follow ALU ops only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (ex_valid && is_alu) begin
			flags[flag_zero] <= alu_result == '0;
			flags[flag_sign] <= alu_result[31];
			flags[flag_overflow] <= alu_overflow;
		end
	end

	// register writeback at the end of this cycle
	assign write = ex_valid && is_alu;
	assign write_lower = ex_valid && ex_opcode == op_lli;
	assign write_upper = ex_valid && ex_opcode == op_lui;
	assign write_address = ex_dest;
	assign write_data = is_alu ? alu_result : ex_imm;

	////////////////////////////////////////////////////////////
	// sprite command issue
	////////////////////////////////////////////////////////////

	always_comb begin
		case (ex_opcode)
			op_dfb:  op = sprite_dfb;
			op_ls:   op = sprite_ls;
			op_ds:   op = sprite_ds;
			op_cs:   op = sprite_cs;
			op_rs:   op = sprite_rs;
			default: op = sprite_wfb;
		endcase
	end

	// wait in place until the port is free
	assign ex_stall = ex_valid && is_sprite && busy;
	assign issue = ex_valid && is_sprite && !busy;
	assign tag = ex_dest;
	assign data = ex_op1;

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter int imem_addr_width = 8
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       run,
	input  logic                       prog_write,
	input  logic [imem_addr_width-1:0] prog_address,
	input  cpu_pkg::word_t             prog_data,
	input  logic                       stall,
	input  logic                       redirect,
	input  logic [imem_addr_width-1:0] redirect_pc,
	output cpu_pkg::word_t             instruction,
	output logic [imem_addr_width-1:0] instruction_pc
);
	import cpu_pkg::*;

	word_t imem [2**imem_addr_width];
	word_t imem_q;
	logic pc_reset;
	logic running;
	logic [imem_addr_width-1:0] pc;
	logic [imem_addr_width-1:0] pc_ghost;

	// pc_ghost is the address whose word sits in imem_q
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_reset <= 1'b1;
			running <= 1'b0;
			pc_ghost <= '0;
		end else begin
			pc_reset <= 1'b0;
			running <= run;
			pc_ghost <= pc;
		end
	end

	always_comb begin
		if (pc_reset || !running) begin
			pc = '0;
		end else if (redirect) begin
			pc = redirect_pc;
		end else if (stall) begin
			// same address again keeps imem_q unchanged
			pc = pc_ghost;
		end else begin
			pc = pc_ghost + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (prog_write) begin
			imem[prog_address] <= prog_data;
		end
		imem_q <= imem[pc];
	end

	// zero word is a no-op for decode
	assign instruction = running ? imem_q : '0;
	assign instruction_pc = pc_ghost;

	// program loading only happens once the pipeline has drained
	assert property (@(posedge clk) disable iff (!rst_n) prog_write |-> !redirect)
		else $error("redirect while the program is being loaded");

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::reg_addr_t read_address1,
	input  cpu_pkg::reg_addr_t read_address2,
	input  logic               write,
	input  logic               write_lower,
	input  logic               write_upper,
	input  cpu_pkg::reg_addr_t write_address,
	input  cpu_pkg::word_t     write_data,
	output cpu_pkg::word_t     read_data1,
	output cpu_pkg::word_t     read_data2
);
	import cpu_pkg::*;

	word_t regs [32];
	logic write_any;

	// r0 stays zero
	assign write_any = (write || write_lower || write_upper) && write_address != '0;

	// upper half writes take the immediate's low bits
	function automatic word_t merge(input word_t stored, input logic lower,
		input logic upper, input word_t value);
		word_t result;
		result = stored;
		if (lower) begin
			result[15:0] = value[15:0];
		end else if (upper) begin
			result[31:16] = value[15:0];
		end else begin
			result = value;
		end
		return result;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_any) begin
			regs[write_address] <= merge(regs[write_address], write_lower, write_upper,
				write_data);
		end
	end

	// write-through on both read ports
	always_comb begin
		read_data1 = regs[read_address1];
		read_data2 = regs[read_address2];
		if (write_any && write_address == read_address1) begin
			read_data1 = merge(regs[read_address1], write_lower, write_upper, write_data);
		end
		if (write_any && write_address == read_address2) begin
			read_data2 = merge(regs[read_address2], write_lower, write_upper, write_data);
		end
	end

endmodule

// File: verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int imem_addr_width = 8;
	localparam int num_tests = 9;
	localparam int wait_limit = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic run;
	logic prog_write;
	logic [imem_addr_width-1:0] prog_address;
	word_t prog_data;
	logic cmd_ack;
	logic cmd_req;
	sprite_op_t cmd_op;
	reg_addr_t cmd_tag;
	word_t cmd_data;

	// stimulus table with one row per program
	string test_name [num_tests];
	word_t program_words [num_tests][16];
	int word_count [num_tests];
	int cmd_count [num_tests];
	sprite_op_t exp_op [num_tests][4];
	reg_addr_t exp_tag [num_tests][4];
	word_t exp_data [num_tests][4];

	int mismatches = 0;
	int protocol_errors = 0;
	int timeouts = 0;
	logic [7:0] lfsr_state = 8'd45;
	logic req_seen = 1'b0;
	logic ack_seen = 1'b0;

	cpu_top #(.imem_addr_width(imem_addr_width)) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.prog_write(prog_write),
		.prog_address(prog_address),
		.prog_data(prog_data),
		.cmd_ack(cmd_ack),
		.cmd_req(cmd_req),
		.cmd_op(cmd_op),
		.cmd_tag(cmd_tag),
		.cmd_data(cmd_data)
	);

	always #5 clk = ~clk;

	// req may only fall once ack was seen high
	always @(posedge clk) begin
		if (rst_n && req_seen && !cmd_req && !ack_seen) begin
			protocol_errors++;
			$display("cmd_req dropped before cmd_ack was raised");
		end
		req_seen <= cmd_req;
		ack_seen <= cmd_ack;
	end

	////////////////////////////////////////////////////////////
	// instruction encoding
	////////////////////////////////////////////////////////////

	function automatic word_t alu_word(input opcode_t op, input reg_addr_t d,
		input reg_addr_t s1, input reg_addr_t s2);
		return {op, d, s1, s2, 12'd0};
	endfunction

	function automatic word_t imm_word(input opcode_t op, input reg_addr_t d,
		input reg_addr_t s1, input logic [15:0] imm);
		return {op, d, s1, 1'b0, imm};
	endfunction

	function automatic word_t branch_word(input opcode_t op, input branch_cond_t c,
		input logic [15:0] offset);
		return {op, c, 8'd0, offset};
	endfunction

	function automatic word_t sprite_word(input opcode_t op, input reg_addr_t tag,
		input reg_addr_t src);
		return {op, tag, src, 17'd0};
	endfunction

	// branch rule on zero, sign and overflow
	function automatic logic condition_met(input branch_cond_t c, input logic z,
		input logic s, input logic o);
		case (c)
			cond_ne:       return !z;
			cond_eq:       return z;
			cond_gt:       return !z && !s;
			cond_lt:       return !z && s;
			cond_ge:       return z || !s;
			cond_le:       return z || s;
			cond_overflow: return o;
			default:       return 1'b1;
		endcase
	endfunction

	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	////////////////////////////////////////////////////////////
	// table building
	////////////////////////////////////////////////////////////

	task automatic put_word(input int t, input word_t w);
		program_words[t][word_count[t]] = w;
		word_count[t]++;
	endtask

	task automatic expect_cmd(input int t, input sprite_op_t o, input reg_addr_t g,
		input word_t d);
		exp_op[t][cmd_count[t]] = o;
		exp_tag[t][cmd_count[t]] = g;
		exp_data[t][cmd_count[t]] = d;
		cmd_count[t]++;
	endtask

	// lui then lli on the same register with no gap
	task automatic load_constant(input int t, input reg_addr_t r, input word_t value);
		put_word(t, imm_word(op_lui, r, 5'd0, value[31:16]));
		put_word(t, imm_word(op_lli, r, 5'd0, value[15:0]));
	endtask

	// every program parks in a branch to itself
	task automatic finish_program(input int t);
		put_word(t, branch_word(op_b, cond_always, 16'hFFFF));
	endtask

	task automatic alu_then_show(input int t, input opcode_t op, input reg_addr_t d,
		input word_t result);
		put_word(t, alu_word(op, d, 5'd1, 5'd2));
		put_word(t, sprite_word(op_ds, d, d));
		expect_cmd(t, sprite_ds, d, result);
	endtask

	task automatic branch_program(input int t, input word_t x, input word_t y,
		input branch_cond_t c0, input branch_cond_t c1, input branch_cond_t c2,
		input branch_cond_t c3);
		branch_cond_t conds [4];
		word_t diff;
		longint full;
		logic z, s, o;
		conds = '{c0, c1, c2, c3};
		diff = x - y;
		full = longint'($signed(x)) - longint'($signed(y));
		z = diff == '0;
		s = diff[31];
		// signed overflow when the true difference does not fit in 32 bits
		o = full != longint'($signed(diff));
		load_constant(t, 5'd1, x);
		load_constant(t, 5'd2, y);
		put_word(t, alu_word(op_sub, 5'd3, 5'd1, 5'd2));
		for (int i = 0; i < 4; i++) begin
			put_word(t, branch_word(op_b, conds[i], 16'd1));
			put_word(t, sprite_word(op_rs, reg_addr_t'(conds[i]), 5'd3));
			if (!condition_met(conds[i], z, s, o)) begin
				expect_cmd(t, sprite_rs, reg_addr_t'(conds[i]), diff);
			end
		end
		finish_program(t);
	endtask

	task automatic build_table();
		word_t a;
		word_t b;
		word_t c;
		a = 32'h9234_5678;
		b = 32'h0F0F_0F24;
		c = 32'hCAFE_BABE;
		for (int t = 0; t < num_tests; t++) begin
			word_count[t] = 0;
			cmd_count[t] = 0;
			for (int i = 0; i < 16; i++) begin
				program_words[t][i] = '0;
			end
		end

		test_name[0] = "alu_arith";
		load_constant(0, 5'd1, a);
		load_constant(0, 5'd2, b);
		alu_then_show(0, op_add, 5'd3, a + b);
		alu_then_show(0, op_sub, 5'd4, a - b);
		alu_then_show(0, op_and, 5'd5, a & b);
		alu_then_show(0, op_or, 5'd6, a | b);
		finish_program(0);

		// shift amount is b[4:0]
		test_name[1] = "alu_shift";
		load_constant(1, 5'd1, a);
		load_constant(1, 5'd2, b);
		alu_then_show(1, op_xor, 5'd7, a ^ b);
		alu_then_show(1, op_sll, 5'd8, a << b[4:0]);
		alu_then_show(1, op_srl, 5'd9, a >> b[4:0]);
		alu_then_show(1, op_sra, 5'd10, word_t'($signed(a) >>> b[4:0]));
		finish_program(1);

		test_name[2] = "write_through";
		load_constant(2, 5'd5, c);
		put_word(2, alu_word(op_add, 5'd6, 5'd5, 5'd5));
		put_word(2, sprite_word(op_ds, 5'd6, 5'd6));
		put_word(2, sprite_word(op_ds, 5'd5, 5'd5));
		expect_cmd(2, sprite_ds, 5'd6, c + c);
		expect_cmd(2, sprite_ds, 5'd5, c);
		finish_program(2);

		test_name[3] = "branch_neg";
		branch_program(3, 32'd3, 32'd5, cond_ne, cond_eq, cond_gt, cond_lt);
		test_name[4] = "branch_zero";
		branch_program(4, 32'd7, 32'd7, cond_ge, cond_le, cond_lt, cond_overflow);
		test_name[5] = "branch_pos";
		branch_program(5, 32'd9, 32'd2, cond_gt, cond_ge, cond_le, cond_lt);
		test_name[6] = "branch_ovf";
		branch_program(6, 32'h8000_0000, 32'd1, cond_overflow, cond_always, cond_eq, cond_ne);

		// routine at word 5 returns to word 2
		test_name[7] = "call_return";
		put_word(7, imm_word(op_addi, 5'd1, 5'd0, 16'h0011));
		put_word(7, branch_word(op_bl, cond_always, 16'd3));
		put_word(7, sprite_word(op_ls, 5'd2, 5'd1));
		finish_program(7);
		put_word(7, sprite_word(op_rs, 5'd4, 5'd1));
		put_word(7, sprite_word(op_cs, 5'd5, 5'd1));
		put_word(7, {op_ret, 27'd0});
		put_word(7, sprite_word(op_rs, 5'd7, 5'd1));
		expect_cmd(7, sprite_cs, 5'd5, 32'h11);
		expect_cmd(7, sprite_ls, 5'd2, 32'h11);

		test_name[8] = "burst";
		put_word(8, imm_word(op_addi, 5'd1, 5'd0, 16'd10));
		put_word(8, sprite_word(op_wfb, 5'd1, 5'd1));
		put_word(8, imm_word(op_addi, 5'd1, 5'd1, 16'd1));
		put_word(8, sprite_word(op_dfb, 5'd2, 5'd1));
		put_word(8, imm_word(op_addi, 5'd1, 5'd1, 16'd1));
		put_word(8, sprite_word(op_ds, 5'd3, 5'd1));
		put_word(8, imm_word(op_addi, 5'd1, 5'd1, 16'd1));
		put_word(8, sprite_word(op_cs, 5'd4, 5'd1));
		finish_program(8);
		expect_cmd(8, sprite_wfb, 5'd1, 32'd10);
		expect_cmd(8, sprite_dfb, 5'd2, 32'd11);
		expect_cmd(8, sprite_ds, 5'd3, 32'd12);
		expect_cmd(8, sprite_cs, 5'd4, 32'd13);
	endtask

	////////////////////////////////////////////////////////////
	// receiver side of the command port
	////////////////////////////////////////////////////////////

	// three lfsr bits give 0 to 7 cycles
	task automatic ack_delay(output int d);
		d = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			d = (d << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic receive_command(input int t, input int c);
		int cycles;
		int delay;
		cycles = 0;
		@(posedge clk);
		while (!cmd_req && cycles < wait_limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!cmd_req) begin
			timeouts++;
			$display("%s: command %0d did not arrive within %0d cycles", test_name[t], c,
				wait_limit);
		end else begin
			if (cmd_op !== exp_op[t][c] || cmd_tag !== exp_tag[t][c]
				|| cmd_data !== exp_data[t][c]) begin
				mismatches++;
				$display("Mismatch %s command %0d: expected op %0d tag %0d data %08h, %s",
					test_name[t], c, exp_op[t][c], exp_tag[t][c], exp_data[t][c],
					$sformatf("actual op %0d tag %0d data %08h", cmd_op, cmd_tag, cmd_data));
			end
			ack_delay(delay);
			repeat (delay) @(posedge clk);
			cmd_ack <= 1'b1;
			cycles = 0;
			@(posedge clk);
			while (cmd_req && cycles < wait_limit) begin
				@(posedge clk);
				cycles++;
			end
			if (cmd_req) begin
				timeouts++;
				$display("%s: cmd_req stayed high after cmd_ack", test_name[t]);
			end
			cmd_ack <= 1'b0;
		end
	endtask

	task automatic check_quiet(input int t);
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			if (cmd_req) begin
				protocol_errors++;
				$display("%s: a command arrived beyond the expected list", test_name[t]);
				break;
			end
		end
	endtask

	task automatic load_program(input int t);
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			prog_write <= 1'b1;
			prog_address <= imem_addr_width'(i);
			prog_data <= program_words[t][i];
		end
		@(posedge clk);
		prog_write <= 1'b0;
	endtask

	task automatic run_program(input int t);
		load_program(t);
		run <= 1'b1;
		for (int c = 0; c < cmd_count[t]; c++) begin
			if (timeouts == 0) begin
				receive_command(t, c);
			end
		end
		if (timeouts == 0) begin
			check_quiet(t);
		end
		@(posedge clk);
		run <= 1'b0;
		// pipeline drains to no-ops before the next load
		repeat (4) @(posedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		prog_write = 1'b0;
		prog_address = '0;
		prog_data = '0;
		cmd_ack = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// burst program has a command at word 1, held back while run is low
		load_program(8);
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			if (cmd_req) begin
				protocol_errors++;
				$display("cmd_req rose while run was low after reset");
			end
		end

		for (int t = 0; t < num_tests; t++) begin
			if (timeouts == 0) begin
				run_program(t);
			end
		end

		$display("errors: %0d mismatches, %0d protocol errors, %0d timeouts",
			mismatches, protocol_errors, timeouts);
		if (mismatches == 0 && protocol_errors == 0 && timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
